//--- flist.f
hw/video_pkg.sv
hw/video_timing.sv
hw/video_regs.sv
hw/layer_render.sv
hw/color_mix.sv
hw/palette_out.sv
hw/video_top.sv
verification/tb_video_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the tile video testbench with Verilator and run it.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_video_top \
    -Mdir obj_dir -o sim_video \
    -f flist.f

./obj_dir/sim_video | tee sim.log

if grep -q "PASS: all tests" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

//--- verification/tb_video_top.sv
// ####################################################################
// Testbench for the tile video top. Drives the CPU bus, shadows the
// maps, palette and registers, and checks raster, readback and RGB
// output with concurrent assertions against a pixel reference model.
// ####################################################################

`timescale 1ns/1ps

module tb_video_top;
    import video_pkg::*;

    logic       clk;
    logic       rst;
    logic       pxl_cen = 1'b0;
    logic       cs;
    logic       we;
    bus_addr_t  addr;
    bus_data_t  wdata;
    bus_data_t  rdata;
    coord_t     hdump;
    coord_t     vdump;
    logic       hsync;
    logic       vsync;
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
    logic       active_dly;

    // Shadow state follows DUT writes on the same edge
    tile_code_t sh_map_a [map_entries];
    tile_code_t sh_map_b [map_entries];
    rgb12_t     sh_pal [pal_entries];
    scroll_t    sh_hscr_a;
    scroll_t    sh_vscr_a;
    scroll_t    sh_hscr_b;
    scroll_t    sh_vscr_b;
    logic       sh_prio_b;
    logic       sh_en_a;
    logic       sh_en_b;

    // Oldest history entry lines up with the RGB output
    logic [pipe_depth-1:0]        act_hist;
    logic [pipe_depth-1:0]        ok_hist;
    logic [pipe_depth-1:0][23:0]  rgb_hist;

    logic      hs_exp;
    logic      vs_exp;
    logic      model_on;
    logic      rd_pending;
    bus_data_t rd_exp;
    int        errors;
    int        seed;

    video_top UUT (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen),
        .cs(cs), .we(we), .addr(addr), .wdata(wdata), .rdata(rdata),
        .hdump(hdump), .vdump(vdump), .hsync(hsync), .vsync(vsync),
        .red(red), .green(green), .blue(blue), .active_dly(active_dly)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        pxl_cen <= ~pxl_cen;
    end

    // Sync pulse windows from the raster definition
    assign hs_exp = hdump inside {[hs_start:hs_end - 1]};
    assign vs_exp = vdump inside {[vs_start:vs_end - 1]};

    function automatic logic pos_active(coord_t h, coord_t v);
        return h < h_active && v < v_active;
    endfunction

    // Reference pixel for one raster position from the shadow state
    function automatic logic [23:0] expected_rgb(coord_t h, coord_t v);
        coord_t     ax;
        coord_t     ay;
        coord_t     bx;
        coord_t     by;
        tile_code_t ca;
        tile_code_t cb;
        pxl_code_t  p;
        rgb12_t     e;
        ax = h + sh_hscr_a;
        ay = v + sh_vscr_a;
        bx = h + sh_hscr_b;
        by = v + sh_vscr_b;
        ca = sh_en_a ? sh_map_a[ay[5:3] * 8 + ax[5:3]] : 4'h0;
        cb = sh_en_b ? sh_map_b[by[5:3] * 8 + bx[5:3]] : 4'h0;
        p = '0;
        if (sh_prio_b && cb != 0) begin
            p = {1'b1, cb};
        end else if (ca != 0) begin
            p = {1'b0, ca};
        end else if (cb != 0) begin
            p = {1'b1, cb};
        end
        if (!pos_active(h, v)) begin
            return '0;
        end
        e = sh_pal[p];
        return {e[11:8], e[11:8], e[7:4], e[7:4], e[3:0], e[3:0]};
    endfunction

    function automatic bus_data_t read_model(bus_addr_t a);
        case (a)
            reg_hscr_a: return {10'd0, sh_hscr_a};
            reg_vscr_a: return {10'd0, sh_vscr_a};
            reg_hscr_b: return {10'd0, sh_hscr_b};
            reg_vscr_b: return {10'd0, sh_vscr_b};
            reg_ctrl:   return {13'd0, sh_en_b, sh_en_a, sh_prio_b};
            default:    return '0;
        endcase
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            sh_hscr_a <= '0;
            sh_vscr_a <= '0;
            sh_hscr_b <= '0;
            sh_vscr_b <= '0;
            sh_prio_b <= 1'b0;
            sh_en_a   <= 1'b0;
            sh_en_b   <= 1'b0;
        end else if (cs && we) begin
            if (addr < map_b_base) begin
                sh_map_a[addr[5:0]] <= wdata[3:0];
            end else if (addr < pal_base) begin
                sh_map_b[addr[5:0]] <= wdata[3:0];
            end else if (addr < pal_base + pal_entries) begin
                sh_pal[addr[4:0]] <= wdata[11:0];
            end else if (addr == reg_hscr_a) begin
                sh_hscr_a <= wdata[5:0];
            end else if (addr == reg_vscr_a) begin
                sh_vscr_a <= wdata[5:0];
            end else if (addr == reg_hscr_b) begin
                sh_hscr_b <= wdata[5:0];
            end else if (addr == reg_vscr_b) begin
                sh_vscr_b <= wdata[5:0];
            end else if (addr == reg_ctrl) begin
                sh_prio_b <= wdata[0];
                sh_en_a   <= wdata[1];
                sh_en_b   <= wdata[2];
            end
        end
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            act_hist   <= '0;
            ok_hist    <= '0;
            rgb_hist   <= '0;
            rd_pending <= 1'b0;
            rd_exp     <= '0;
        end else begin
            if (pxl_cen) begin
                act_hist <= {act_hist[pipe_depth-2:0], pos_active(hdump, vdump)};
                rgb_hist <= {rgb_hist[pipe_depth-2:0], expected_rgb(hdump, vdump)};
                ok_hist  <= {ok_hist[pipe_depth-2:0], model_on};
            end
            // Pixels in flight across a write mix old and new state
            if (cs && we) begin
                ok_hist <= '0;
            end
            rd_pending <= cs && !we;
            if (cs && !we) begin
                rd_exp <= read_model(addr);
            end
        end
    end

    a_hstep: assert property (@(posedge clk) disable iff (rst)
        pxl_cen && hdump != h_total - 1 |=> hdump == $past(hdump) + 1 && vdump == $past(vdump))
        else begin
            errors = errors + 1;
            $display("FAIL hdump step got %h after %h", $sampled(hdump), $past(hdump));
        end

    a_wrap: assert property (@(posedge clk) disable iff (rst)
        pxl_cen && hdump == h_total - 1 |=> hdump == 0 &&
        vdump == (($past(vdump) == v_total - 1) ? 0 : $past(vdump) + 1))
        else begin
            errors = errors + 1;
            $display("FAIL vdump wrap got %h after %h", $sampled(vdump), $past(vdump));
        end

    a_hold: assert property (@(posedge clk) disable iff (rst)
        !pxl_cen |=> $stable(hdump) && $stable(vdump))
        else begin
            errors = errors + 1;
            $display("FAIL hdump/vdump hold exp %h/%h got %h/%h",
                $past(hdump), $past(vdump), $sampled(hdump), $sampled(vdump));
        end

    a_sync_blank: assert property (@(posedge clk) disable iff (rst)
        (!hsync || hdump >= h_active) && (!vsync || vdump >= v_active))
        else begin
            errors = errors + 1;
            $display("sync pulse seen outside the blanking interval");
        end

    a_sync_window: assert property (@(posedge clk) disable iff (rst)
        hsync == hs_exp && vsync == vs_exp)
        else begin
            errors = errors + 1;
            $display("FAIL hsync/vsync exp %h/%h got %h/%h",
                $sampled(hs_exp), $sampled(vs_exp), $sampled(hsync), $sampled(vsync));
        end

    a_active: assert property (@(posedge clk) disable iff (rst)
        active_dly == act_hist[pipe_depth-1])
        else begin
            errors = errors + 1;
            $display("FAIL active_dly exp %h got %h",
                $sampled(act_hist[pipe_depth-1]), $sampled(active_dly));
        end

    a_rgb: assert property (@(posedge clk) disable iff (rst)
        ok_hist[pipe_depth-1] |-> {red, green, blue} == rgb_hist[pipe_depth-1])
        else begin
            errors = errors + 1;
            $display("FAIL rgb exp %h got %h",
                $sampled(rgb_hist[pipe_depth-1]), $sampled({red, green, blue}));
        end

    a_blank_black: assert property (@(posedge clk) disable iff (rst)
        !active_dly |-> {red, green, blue} == 24'h0)
        else begin
            errors = errors + 1;
            $display("FAIL rgb in blanking got %h", $sampled({red, green, blue}));
        end

    a_readback: assert property (@(posedge clk) disable iff (rst)
        rd_pending |-> rdata == rd_exp)
        else begin
            errors = errors + 1;
            $display("FAIL rdata exp %h got %h", $sampled(rd_exp), $sampled(rdata));
        end

    a_reset_state: assert property (@(posedge clk)
        $fell(rst) |-> !hsync && !vsync && !active_dly && rdata == 0 &&
        {red, green, blue} == 24'h0)
        else begin
            errors = errors + 1;
            $display("outputs not in their reset state right after reset");
        end

    task automatic bus_write(bus_addr_t a, bus_data_t d);
        @(posedge clk);
        cs    <= 1'b1;
        we    <= 1'b1;
        addr  <= a;
        wdata <= d;
        @(posedge clk);
        cs <= 1'b0;
        we <= 1'b0;
    endtask

    task automatic bus_read(bus_addr_t a);
        @(posedge clk);
        cs   <= 1'b1;
        we   <= 1'b0;
        addr <= a;
        @(posedge clk);
        cs <= 1'b0;
    endtask

    // Random tiles with roughly a quarter of them transparent
    task automatic fill_memories();
        logic [31:0] r;
        for (int i = 0; i < map_entries; i++) begin
            r = $random(seed);
            bus_write(map_a_base + i, {12'd0, (r[5:4] == 0) ? 4'h0 : r[3:0]});
            r = $random(seed);
            bus_write(map_b_base + i, {12'd0, (r[5:4] == 0) ? 4'h0 : r[3:0]});
        end
        for (int i = 0; i < pal_entries; i++) begin
            r = $random(seed);
            bus_write(pal_base + i, {4'd0, r[11:0]});
        end
    endtask

    task automatic wait_line(coord_t line);
        int n;
        n = 0;
        while (vdump != line && n < 6000) begin
            @(posedge clk);
            n = n + 1;
        end
        if (vdump != line) begin
            errors = errors + 1;
            $display("timeout while waiting for line %0d", line);
            $display("errors: %0d", errors);
            $display("FAIL: see errors above");
            $finish;
        end
    endtask

    task automatic run_frame();
        wait_line(1);
        wait_line(0);
    endtask

    initial begin
        rst      = 1'b1;
        cs       = 1'b0;
        we       = 1'b0;
        addr     = '0;
        wdata    = '0;
        model_on = 1'b0;
        errors   = 0;
        seed     = 32'h10fa45a8;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        bus_read(reg_ctrl);

        bus_write(reg_hscr_a, 16'h0015);
        bus_write(reg_vscr_a, 16'h002a);
        bus_write(reg_hscr_b, 16'h0033);
        bus_write(reg_vscr_b, 16'h000c);
        bus_write(reg_ctrl, 16'h0005);
        for (int a = reg_hscr_a; a <= reg_ctrl; a++) begin
            bus_read(a);
        end
        bus_read(map_a_base + 5);
        bus_read(pal_base + 5);

        fill_memories();
        @(posedge clk);
        model_on <= 1'b1;

        // Layer A alone and then scrolled past the wrap point
        bus_write(reg_hscr_a, 16'h0000);
        bus_write(reg_vscr_a, 16'h0000);
        bus_write(reg_ctrl, 16'h0002);
        run_frame();
        bus_write(reg_hscr_a, 16'h000d);
        bus_write(reg_vscr_a, 16'h0025);
        run_frame();

        // Both layers with A on top and then B on top
        bus_write(reg_hscr_b, 16'h0005);
        bus_write(reg_vscr_b, 16'h0032);
        bus_write(reg_ctrl, 16'h0006);
        run_frame();
        bus_write(reg_ctrl, 16'h0007);
        run_frame();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- hw/video_top.sv
// ####################################################################
// Tile video subsystem top. Raster timing, CPU registers, two tile
// layers, priority mixer and palette output, three pixel steps deep.
// ####################################################################

`timescale 1ns/1ps

module video_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pxl_cen,
    input  logic                 cs,
    input  logic                 we,
    input  video_pkg::bus_addr_t addr,
    input  video_pkg::bus_data_t wdata,
    output video_pkg::bus_data_t rdata,
    output video_pkg::coord_t    hdump,
    output video_pkg::coord_t    vdump,
    output logic                 hsync,
    output logic                 vsync,
    output logic [7:0]           red,
    output logic [7:0]           green,
    output logic [7:0]           blue,
    output logic                 active_dly
);
    import video_pkg::*;

    logic       hblank, vblank;
    logic       map_we_a, map_we_b, pal_we;
    logic [5:0] map_addr;
    logic [4:0] pal_addr;
    tile_code_t map_data;
    rgb12_t     pal_data;
    scroll_t    hscroll_a, vscroll_a, hscroll_b, vscroll_b;
    logic       prio_b, en_a, en_b;
    tile_code_t code_a, code_b;
    pxl_code_t  pxl;

    video_timing u_timing (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen),
        .hdump(hdump), .vdump(vdump),
        .hblank(hblank), .vblank(vblank),
        .hsync(hsync), .vsync(vsync)
    );

    video_regs u_regs (
        .clk(clk), .rst(rst),
        .cs(cs), .we(we), .addr(addr), .wdata(wdata), .rdata(rdata),
        .map_we_a(map_we_a), .map_we_b(map_we_b),
        .map_addr(map_addr), .map_data(map_data),
        .pal_we(pal_we), .pal_addr(pal_addr), .pal_data(pal_data),
        .hscroll_a(hscroll_a), .vscroll_a(vscroll_a),
        .hscroll_b(hscroll_b), .vscroll_b(vscroll_b),
        .prio_b(prio_b), .en_a(en_a), .en_b(en_b)
    );

    layer_render u_layer_a (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen),
        .hdump(hdump), .vdump(vdump),
        .hscroll(hscroll_a), .vscroll(vscroll_a), .enable(en_a),
        .map_we(map_we_a), .map_addr(map_addr), .map_data(map_data),
        .code(code_a)
    );

    layer_render u_layer_b (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen),
        .hdump(hdump), .vdump(vdump),
        .hscroll(hscroll_b), .vscroll(vscroll_b), .enable(en_b),
        .map_we(map_we_b), .map_addr(map_addr), .map_data(map_data),
        .code(code_b)
    );

    color_mix u_mix (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen),
        .code_a(code_a), .code_b(code_b), .prio_b(prio_b),
        .pxl(pxl)
    );

    palette_out u_pal (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen),
        .pxl(pxl), .hblank(hblank), .vblank(vblank),
        .pal_we(pal_we), .pal_addr(pal_addr), .pal_data(pal_data),
        .red(red), .green(green), .blue(blue),
        .active_dly(active_dly)
    );

endmodule

//--- hw/palette_out.sv
// ####################################################################
// Palette stage. Turns the mixed pixel code into 8-bit RGB and delays
// the blanking flags so active_dly lines up with the colour output.
// ####################################################################

`timescale 1ns/1ps

module palette_out (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pxl_cen,
    input  video_pkg::pxl_code_t pxl,
    input  logic                 hblank,
    input  logic                 vblank,
    input  logic                 pal_we,
    input  logic [4:0]           pal_addr,
    input  video_pkg::rgb12_t    pal_data,
    output logic [7:0]           red,
    output logic [7:0]           green,
    output logic [7:0]           blue,
    output logic                 active_dly
);
    import video_pkg::*;

    rgb12_t pal_ram [pal_entries];

    rgb12_t                  entry;
    logic [pipe_depth-1:0]   active_sr;
    logic                    pxl_active;

    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal_ram[pal_addr] <= pal_data;
        end
    end

    assign entry = pal_ram[pxl];

    // Stage pipe_depth-2 is the flag for the pixel now at the input
    assign pxl_active = active_sr[pipe_depth-2];
    assign active_dly = active_sr[pipe_depth-1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active_sr <= '0;
        end else if (pxl_cen) begin
            active_sr <= {active_sr[pipe_depth-2:0], ~(hblank | vblank)};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (pxl_cen) begin
            if (pxl_active) begin
                // Repeat each nibble to fill 8 bits
                red   <= {entry[11:8], entry[11:8]};
                green <= {entry[7:4], entry[7:4]};
                blue  <= {entry[3:0], entry[3:0]};
            end else begin
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end
        end
    end

endmodule

//--- hw/color_mix.sv
// ####################################################################
// Priority mixer for the two tile layers. Code 0 is transparent and
// lets the lower layer, then the backdrop, show through.
// ####################################################################

`timescale 1ns/1ps

module color_mix (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pxl_cen,
    input  video_pkg::tile_code_t code_a,
    input  video_pkg::tile_code_t code_b,
    input  logic                  prio_b,
    output video_pkg::pxl_code_t  pxl
);
    import video_pkg::*;

    pxl_code_t mix;
    logic      opaque_a;
    logic      opaque_b;

    assign opaque_a = code_a != '0;
    assign opaque_b = code_b != '0;

    always_comb begin
        mix = '0;
        if (prio_b) begin
            if (opaque_b) begin
                mix = {1'b1, code_b};
            end else if (opaque_a) begin
                mix = {1'b0, code_a};
            end
        end else begin
            if (opaque_a) begin
                mix = {1'b0, code_a};
            end else if (opaque_b) begin
                mix = {1'b1, code_b};
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            pxl <= mix;
        end
    end

endmodule

//--- hw/layer_render.sv
// ####################################################################
// One scrolling tile layer. Holds an 8x8 map of solid colour tiles
// and returns the tile code under the scrolled raster position, one
// pixel step after hdump/vdump.
// ####################################################################

`timescale 1ns/1ps

module layer_render (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pxl_cen,
    input  video_pkg::coord_t     hdump,
    input  video_pkg::coord_t     vdump,
    input  video_pkg::scroll_t    hscroll,
    input  video_pkg::scroll_t    vscroll,
    input  logic                  enable,
    input  logic                  map_we,
    input  logic [5:0]            map_addr,
    input  video_pkg::tile_code_t map_data,
    output video_pkg::tile_code_t code
);
    import video_pkg::*;

    tile_code_t map_ram [map_entries];

    coord_t     lx;
    coord_t     ly;
    logic [5:0] tile_idx;

    // Layer space is 64x64, so the 6-bit sums wrap on their own
    assign lx = hdump + hscroll;
    assign ly = vdump + vscroll;

    // Tiles are 8x8 pixels, map is row major
    assign tile_idx = {ly[5:3], lx[5:3]};

    // CPU side write port
    always_ff @(posedge clk) begin
        if (map_we) begin
            map_ram[map_addr] <= map_data;
        end
    end

    // Synchronous lookup on the pixel step
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            code <= '0;
        end else if (pxl_cen) begin
            if (enable) begin
                code <= map_ram[tile_idx];
            end else begin
                // A disabled layer is fully transparent
                code <= '0;
            end
        end
    end

endmodule

//--- hw/video_regs.sv
// ####################################################################
// CPU bus decoder. Writes go to the tile maps, the palette or the
// scroll and control registers; reads return the registers only.
// ####################################################################

`timescale 1ns/1ps

module video_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cs,
    input  logic                  we,
    input  video_pkg::bus_addr_t  addr,
    input  video_pkg::bus_data_t  wdata,
    output video_pkg::bus_data_t  rdata,
    output logic                  map_we_a,
    output logic                  map_we_b,
    output logic [5:0]            map_addr,
    output video_pkg::tile_code_t map_data,
    output logic                  pal_we,
    output logic [4:0]            pal_addr,
    output video_pkg::rgb12_t     pal_data,
    output video_pkg::scroll_t    hscroll_a,
    output video_pkg::scroll_t    vscroll_a,
    output video_pkg::scroll_t    hscroll_b,
    output video_pkg::scroll_t    vscroll_b,
    output logic                  prio_b,
    output logic                  en_a,
    output logic                  en_b
);
    import video_pkg::*;

    logic wr;
    logic reg_we;

    assign wr = cs && we;

    // Region decode, strobes land on the same edge as the bus cycle
    assign map_we_a = wr && addr[7:6] == map_a_base[7:6];
    assign map_we_b = wr && addr[7:6] == map_b_base[7:6];
    assign pal_we   = wr && addr[7:5] == pal_base[7:5];
    assign reg_we   = wr && addr >= reg_hscr_a && addr <= reg_ctrl;

    assign map_addr = addr[5:0];
    assign map_data = wdata[3:0];
    assign pal_addr = addr[4:0];
    assign pal_data = wdata[11:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hscroll_a <= '0;
            vscroll_a <= '0;
            hscroll_b <= '0;
            vscroll_b <= '0;
            prio_b    <= 1'b0;
            en_a      <= 1'b0;
            en_b      <= 1'b0;
        end else if (reg_we) begin
            case (addr)
                reg_hscr_a: hscroll_a <= wdata[5:0];
                reg_vscr_a: vscroll_a <= wdata[5:0];
                reg_hscr_b: hscroll_b <= wdata[5:0];
                reg_vscr_b: vscroll_b <= wdata[5:0];
                default: begin
                    prio_b <= wdata[0];
                    en_a   <= wdata[1];
                    en_b   <= wdata[2];
                end
            endcase
        end
    end

    // Read data is held until the next read cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata <= '0;
        end else if (cs && !we) begin
            case (addr)
                reg_hscr_a: rdata <= bus_data_t'(hscroll_a);
                reg_vscr_a: rdata <= bus_data_t'(vscroll_a);
                reg_hscr_b: rdata <= bus_data_t'(hscroll_b);
                reg_vscr_b: rdata <= bus_data_t'(vscroll_b);
                reg_ctrl:   rdata <= bus_data_t'({en_b, en_a, prio_b});
                default:    rdata <= '0;
            endcase
        end
    end

    a_one_strobe: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({map_we_a, map_we_b, pal_we, reg_we})
    );

endmodule

//--- hw/video_timing.sv
// ####################################################################
// Raster generator. Pixel and line counters advance on pxl_cen and
// give blanking and sync flags for the current position.
// ####################################################################

`timescale 1ns/1ps

module video_timing (
    input  logic              clk,
    input  logic              rst,
    input  logic              pxl_cen,
    output video_pkg::coord_t hdump,
    output video_pkg::coord_t vdump,
    output logic              hblank,
    output logic              vblank,
    output logic              hsync,
    output logic              vsync
);
    import video_pkg::*;

    logic line_end;
    logic frame_end;

    assign line_end  = hdump == coord_t'(h_total - 1);
    assign frame_end = vdump == coord_t'(v_total - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdump <= '0;
            vdump <= '0;
        end else if (pxl_cen) begin
            if (line_end) begin
                hdump <= '0;
                // Lines step once per wrap of the pixel counter
                if (frame_end) begin
                    vdump <= '0;
                end else begin
                    vdump <= vdump + 1'b1;
                end
            end else begin
                hdump <= hdump + 1'b1;
            end
        end
    end

    // Flags follow the counters directly
    assign hblank = hdump >= coord_t'(h_active);
    assign vblank = vdump >= coord_t'(v_active);
    assign hsync  = hdump >= coord_t'(hs_start) && hdump < coord_t'(hs_end);
    assign vsync  = vdump >= coord_t'(vs_start) && vdump < coord_t'(vs_end);

    a_counter_range: assert property (
        @(posedge clk) disable iff (rst)
        hdump < h_total && vdump < v_total
    );

endmodule

//--- hw/video_pkg.sv
// ####################################################################
// Shared raster sizes, CPU register map and data widths for the
// tile video subsystem. Modules take it by wildcard import.
// ####################################################################

package video_pkg;

    // Raster, deliberately tiny so whole frames simulate quickly
    localparam int h_total  = 64;
    localparam int h_active = 48;
    localparam int v_total  = 40;
    localparam int v_active = 32;

    // Sync pulses sit inside the blanking interval
    localparam int hs_start = 52;
    localparam int hs_end   = 56;
    localparam int vs_start = 34;
    localparam int vs_end   = 36;

    // Pixel steps from raster position to RGB
    localparam int pipe_depth = 3;

    // Memory sizes
    localparam int map_entries = 64;
    localparam int pal_entries = 32;

    typedef logic [5:0]  coord_t;
    typedef logic [5:0]  scroll_t;
    // Colour code of one tile, 0 is transparent
    typedef logic [3:0]  tile_code_t;
    // Layer bit on top, colour code below, 0 is backdrop
    typedef logic [4:0]  pxl_code_t;
    // 4 bits per channel, red in the high nibble
    typedef logic [11:0] rgb12_t;

    typedef logic [7:0]  bus_addr_t;
    typedef logic [15:0] bus_data_t;

    // CPU register map
    localparam bus_addr_t map_a_base = 8'h00;
    localparam bus_addr_t map_b_base = 8'h40;
    localparam bus_addr_t pal_base   = 8'h80;
    localparam bus_addr_t reg_hscr_a = 8'hA0;
    localparam bus_addr_t reg_vscr_a = 8'hA1;
    localparam bus_addr_t reg_hscr_b = 8'hA2;
    localparam bus_addr_t reg_vscr_b = 8'hA3;
    // bit 0 B over A, bit 1 A on, bit 2 B on
    localparam bus_addr_t reg_ctrl   = 8'hA4;

endpackage
